//--- logic/weighting_pkg.sv
// Shared definitions for the write-weighting block
//   Data and count widths
//   Fixed-point saturation limits and rounding constant
//   Adder opcode and controller state enums

package weighting_pkg;

  // Word and count widths
  localparam int DATA_SIZE  = 32;
  localparam int FRAC_BITS  = 16;
  localparam int SIZE_WIDTH = 16;

  // Signed saturation limits
  localparam logic signed [DATA_SIZE-1:0] Q_MAX = {1'b0, {(DATA_SIZE-1){1'b1}}};
  localparam logic signed [DATA_SIZE-1:0] Q_MIN = {1'b1, {(DATA_SIZE-1){1'b0}}};

  // Half an output LSB at full product width, added before the shift
  localparam logic signed [2*DATA_SIZE-1:0] ROUND_HALF =
    {{(2*DATA_SIZE-1){1'b0}}, 1'b1} << (FRAC_BITS - 1);

  // Adder opcodes
  typedef enum logic {
    OP_ADD,
    OP_SUB
  } op_e;

  // Element sequencer states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_SUB,
    ST_GATE_MUL,
    ST_ADD,
    ST_WRITE_MUL,
    ST_EMIT
  } ctrl_state_e;

endpackage

//--- logic/arith_op_if.sv
// Single-operation link between the sequencer and an arithmetic unit
//   Start pulse with opcode and two operands
//   Result with its done pulse, master and unit modports

interface arith_op_if;

  // Request side, operands valid while start is high
  logic                                     start;
  weighting_pkg::op_e                       operation;
  logic signed [weighting_pkg::DATA_SIZE-1:0] operand_a;
  logic signed [weighting_pkg::DATA_SIZE-1:0] operand_b;

  // Response side
  logic signed [weighting_pkg::DATA_SIZE-1:0] result;
  logic                                     done;

  // Sequencer end
  modport master (
    output start, operation, operand_a, operand_b,
    input  result, done
  );

  // Arithmetic block end
  modport unit (
    input  start, operation, operand_a, operand_b,
    output result, done
  );

endinterface

//--- logic/q_adder.sv
// Saturating fixed-point adder/subtractor
//   One cycle from start to done
//   Sum formed one bit wider, clamped to the signed range

module q_adder (
  input logic      CLK,
  input logic      RST,
  arith_op_if.unit op
);

  // One guard bit above the word
  logic signed [weighting_pkg::DATA_SIZE:0]   sum_wide;
  logic signed [weighting_pkg::DATA_SIZE-1:0] sum_sat;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Explicit sign extension into the guard bit
    if (op.operation == weighting_pkg::OP_SUB) begin
      sum_wide = {op.operand_a[weighting_pkg::DATA_SIZE-1], op.operand_a} -
                 {op.operand_b[weighting_pkg::DATA_SIZE-1], op.operand_b};
    end else begin
      sum_wide = {op.operand_a[weighting_pkg::DATA_SIZE-1], op.operand_a} +
                 {op.operand_b[weighting_pkg::DATA_SIZE-1], op.operand_b};
    end

    // Guard and sign disagree on overflow
    if (sum_wide[weighting_pkg::DATA_SIZE] != sum_wide[weighting_pkg::DATA_SIZE-1]) begin
      sum_sat = sum_wide[weighting_pkg::DATA_SIZE] ? weighting_pkg::Q_MIN
                                                   : weighting_pkg::Q_MAX;
    end else begin
      sum_sat = sum_wide[weighting_pkg::DATA_SIZE-1:0];
    end
  end

  // Done strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      op.done <= 1'b0;
    end else begin
      op.done <= op.start;
    end
  end

  // Result held until the next operation
  always_ff @(posedge CLK) begin
    if (op.start) begin
      op.result <= sum_sat;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Result register loaded with real data whenever done is raised
  a_result_known: assert property (@(posedge CLK) disable iff (RST)
    op.done |-> !$isunknown(op.result));

  a_known_opcode: assert property (@(posedge CLK) disable iff (RST)
    op.start |-> !$isunknown(op.operation));

endmodule

//--- logic/q_multiplier.sv
// Pipelined saturating fixed-point multiplier
//   Stage 1 holds the full signed product
//   Stage 2 rounds half-up, rescales and clamps
//   New start accepted every cycle

module q_multiplier (
  input logic      CLK,
  input logic      RST,
  arith_op_if.unit op
);

  // Stage 1 registers
  logic signed [2*weighting_pkg::DATA_SIZE-1:0] product_q;
  logic                                         valid_q;

  // Stage 2 combinational terms
  logic signed [2*weighting_pkg::DATA_SIZE-1:0] rounded;
  logic signed [2*weighting_pkg::DATA_SIZE-1:0] shifted;
  logic signed [weighting_pkg::DATA_SIZE-1:0]   product_sat;

  ////////////////////////////////////////////////////////////////////////////
  // Stage 1
  ////////////////////////////////////////////////////////////////////////////

  // Valid bit travels with the product
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= op.start;
    end
  end

  // Both operands signed, so the product is sign extended to 64 bits
  always_ff @(posedge CLK) begin
    if (op.start) begin
      product_q <= op.operand_a * op.operand_b;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 2
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // No overflow possible here, |product| is at most 2^62
    rounded = product_q + weighting_pkg::ROUND_HALF;
    // Arithmetic shift back to the Q16 scale
    shifted = rounded >>> weighting_pkg::FRAC_BITS;

    // Clamp to the word range
    if (shifted > weighting_pkg::Q_MAX) begin
      product_sat = weighting_pkg::Q_MAX;
    end else if (shifted < weighting_pkg::Q_MIN) begin
      product_sat = weighting_pkg::Q_MIN;
    end else begin
      product_sat = shifted[weighting_pkg::DATA_SIZE-1:0];
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      op.done <= 1'b0;
    end else begin
      op.done <= valid_q;
    end
  end

  always_ff @(posedge CLK) begin
    if (valid_q) begin
      op.result <= product_sat;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Sequencer must present real operands with every start
  a_known_operands: assert property (@(posedge CLK) disable iff (RST)
    op.start |-> !$isunknown({op.operand_a, op.operand_b}));

endmodule

//--- logic/write_weighting_ctrl.sv
// Element sequencer for the write weighting
//   w(j) = gw * (c(j) + ga * (a(j) - c(j)))
//   Requests a and c per element, then subtract, gate multiply,
//   add and write multiply on the shared units
//   W_OUT strobe per element, READY after the last one

module write_weighting_ctrl (
  input  logic                                CLK,
  input  logic                                RST,
  input  logic                                START,
  output logic                                READY,
  input  logic                                A_IN_ENABLE,
  input  logic                                C_IN_ENABLE,
  output logic                                A_OUT_ENABLE,
  output logic                                C_OUT_ENABLE,
  output logic                                W_OUT_ENABLE,
  input  logic [weighting_pkg::SIZE_WIDTH-1:0] SIZE_N_IN,
  input  logic [weighting_pkg::DATA_SIZE-1:0]  A_IN,
  input  logic [weighting_pkg::DATA_SIZE-1:0]  C_IN,
  input  logic [weighting_pkg::DATA_SIZE-1:0]  GA_IN,
  input  logic [weighting_pkg::DATA_SIZE-1:0]  GW_IN,
  output logic [weighting_pkg::DATA_SIZE-1:0]  W_OUT,
  arith_op_if.master                          add_op,
  arith_op_if.master                          mul_op
);

  // FSM and run control
  weighting_pkg::ctrl_state_e             state;
  logic [weighting_pkg::SIZE_WIDTH-1:0]   n_q;
  logic [weighting_pkg::SIZE_WIDTH-1:0]   count_q;
  logic                                   issue_q;
  logic                                   a_held;
  logic                                   c_held;
  logic                                   both_ready;

  // Operand and intermediate storage
  logic signed [weighting_pkg::DATA_SIZE-1:0] ga_q;
  logic signed [weighting_pkg::DATA_SIZE-1:0] gw_q;
  logic signed [weighting_pkg::DATA_SIZE-1:0] a_q;
  logic signed [weighting_pkg::DATA_SIZE-1:0] c_q;
  logic signed [weighting_pkg::DATA_SIZE-1:0] acc_q;

  // Inputs complete when held or arriving now
  assign both_ready = (a_held || A_IN_ENABLE) && (c_held || C_IN_ENABLE);

  ////////////////////////////////////////////////////////////////////////////
  // Operation issue
  ////////////////////////////////////////////////////////////////////////////

  // Start strobes only in the first cycle of a compute state
  assign add_op.start = issue_q &&
    ((state == weighting_pkg::ST_SUB) || (state == weighting_pkg::ST_ADD));
  assign mul_op.start = issue_q &&
    ((state == weighting_pkg::ST_GATE_MUL) || (state == weighting_pkg::ST_WRITE_MUL));

  // Multiplier has no opcode
  assign mul_op.operation = weighting_pkg::OP_ADD;

  always_comb begin
    // Subtract a - c, then add c + ga*(a - c)
    if (state == weighting_pkg::ST_SUB) begin
      add_op.operation = weighting_pkg::OP_SUB;
      add_op.operand_a = a_q;
      add_op.operand_b = c_q;
    end else begin
      add_op.operation = weighting_pkg::OP_ADD;
      add_op.operand_a = c_q;
      add_op.operand_b = acc_q;
    end

    // Gate by ga first, then by gw
    if (state == weighting_pkg::ST_GATE_MUL) begin
      mul_op.operand_a = ga_q;
    end else begin
      mul_op.operand_a = gw_q;
    end
    mul_op.operand_b = acc_q;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= weighting_pkg::ST_IDLE;
      n_q          <= '0;
      count_q      <= '0;
      issue_q      <= 1'b0;
      a_held       <= 1'b0;
      c_held       <= 1'b0;
      READY        <= 1'b0;
      A_OUT_ENABLE <= 1'b0;
      C_OUT_ENABLE <= 1'b0;
      W_OUT_ENABLE <= 1'b0;
    end else begin
      // Strobes default low
      READY        <= 1'b0;
      A_OUT_ENABLE <= 1'b0;
      C_OUT_ENABLE <= 1'b0;
      W_OUT_ENABLE <= 1'b0;
      issue_q      <= 1'b0;

      case (state)
        weighting_pkg::ST_IDLE: begin
          if (START) begin
            n_q     <= SIZE_N_IN;
            count_q <= '0;
            if (SIZE_N_IN == '0) begin
              // Empty vector, finish at once
              READY <= 1'b1;
            end else begin
              state        <= weighting_pkg::ST_FETCH;
              A_OUT_ENABLE <= 1'b1;
              C_OUT_ENABLE <= 1'b1;
              a_held       <= 1'b0;
              c_held       <= 1'b0;
            end
          end
        end

        weighting_pkg::ST_FETCH: begin
          // a and c may come in any order
          if (A_IN_ENABLE) begin
            a_held <= 1'b1;
          end
          if (C_IN_ENABLE) begin
            c_held <= 1'b1;
          end
          if (both_ready) begin
            state   <= weighting_pkg::ST_SUB;
            issue_q <= 1'b1;
          end
        end

        weighting_pkg::ST_SUB: begin
          if (add_op.done) begin
            state   <= weighting_pkg::ST_GATE_MUL;
            issue_q <= 1'b1;
          end
        end

        weighting_pkg::ST_GATE_MUL: begin
          if (mul_op.done) begin
            state   <= weighting_pkg::ST_ADD;
            issue_q <= 1'b1;
          end
        end

        weighting_pkg::ST_ADD: begin
          if (add_op.done) begin
            state   <= weighting_pkg::ST_WRITE_MUL;
            issue_q <= 1'b1;
          end
        end

        weighting_pkg::ST_WRITE_MUL: begin
          if (mul_op.done) begin
            state        <= weighting_pkg::ST_EMIT;
            W_OUT_ENABLE <= 1'b1;
            count_q      <= count_q + 1'b1;
          end
        end

        weighting_pkg::ST_EMIT: begin
          // W_OUT_ENABLE is high in this cycle
          if (count_q == n_q) begin
            state <= weighting_pkg::ST_IDLE;
            READY <= 1'b1;
          end else begin
            state        <= weighting_pkg::ST_FETCH;
            A_OUT_ENABLE <= 1'b1;
            C_OUT_ENABLE <= 1'b1;
            a_held       <= 1'b0;
            c_held       <= 1'b0;
          end
        end

        default: begin
          state <= weighting_pkg::ST_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    case (state)
      weighting_pkg::ST_IDLE: begin
        if (START) begin
          ga_q <= GA_IN;
          gw_q <= GW_IN;
        end
      end
      weighting_pkg::ST_FETCH: begin
        // Keep the first value of each element
        if (A_IN_ENABLE && !a_held) begin
          a_q <= A_IN;
        end
        if (C_IN_ENABLE && !c_held) begin
          c_q <= C_IN;
        end
      end
      weighting_pkg::ST_SUB, weighting_pkg::ST_ADD: begin
        if (add_op.done) begin
          acc_q <= add_op.result;
        end
      end
      weighting_pkg::ST_GATE_MUL: begin
        if (mul_op.done) begin
          acc_q <= mul_op.result;
        end
      end
      weighting_pkg::ST_WRITE_MUL: begin
        if (mul_op.done) begin
          W_OUT <= mul_op.result;
        end
      end
      default: begin
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Each unit answers only in a state that waits for it
  a_add_done_state: assert property (@(posedge CLK) disable iff (RST)
    add_op.done |-> (state == weighting_pkg::ST_SUB || state == weighting_pkg::ST_ADD));

  a_mul_done_state: assert property (@(posedge CLK) disable iff (RST)
    mul_op.done |->
      (state == weighting_pkg::ST_GATE_MUL || state == weighting_pkg::ST_WRITE_MUL));

  a_no_emit_idle: assert property (@(posedge CLK) disable iff (RST)
    W_OUT_ENABLE |-> (state != weighting_pkg::ST_IDLE));

endmodule

//--- logic/write_weighting_top.sv
// Top level of the write-weighting block
//   Plain-port boundary
//   Sequencer wired to one adder and one multiplier
//   through two operation interfaces

module write_weighting_top (
  input  logic                                CLK,
  input  logic                                RST,
  input  logic                                START,
  output logic                                READY,
  input  logic                                A_IN_ENABLE,
  input  logic                                C_IN_ENABLE,
  output logic                                A_OUT_ENABLE,
  output logic                                C_OUT_ENABLE,
  output logic                                W_OUT_ENABLE,
  input  logic [weighting_pkg::SIZE_WIDTH-1:0] SIZE_N_IN,
  input  logic [weighting_pkg::DATA_SIZE-1:0]  A_IN,
  input  logic [weighting_pkg::DATA_SIZE-1:0]  C_IN,
  input  logic [weighting_pkg::DATA_SIZE-1:0]  GA_IN,
  input  logic [weighting_pkg::DATA_SIZE-1:0]  GW_IN,
  output logic [weighting_pkg::DATA_SIZE-1:0]  W_OUT
);

  // Links to the shared units
  arith_op_if add_if ();
  arith_op_if mul_if ();

  // Element sequencer
  write_weighting_ctrl i_ctrl (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .READY        (READY),
    .A_IN_ENABLE  (A_IN_ENABLE),
    .C_IN_ENABLE  (C_IN_ENABLE),
    .A_OUT_ENABLE (A_OUT_ENABLE),
    .C_OUT_ENABLE (C_OUT_ENABLE),
    .W_OUT_ENABLE (W_OUT_ENABLE),
    .SIZE_N_IN    (SIZE_N_IN),
    .A_IN         (A_IN),
    .C_IN         (C_IN),
    .GA_IN        (GA_IN),
    .GW_IN        (GW_IN),
    .W_OUT        (W_OUT),
    .add_op       (add_if.master),
    .mul_op       (mul_if.master)
  );

  // Subtract and add, one cycle
  q_adder i_adder (
    .CLK (CLK),
    .RST (RST),
    .op  (add_if.unit)
  );

  // Both gate multiplies, two cycles
  q_multiplier i_multiplier (
    .CLK (CLK),
    .RST (RST),
    .op  (mul_if.unit)
  );

endmodule

//--- verif/clock_gen.sv
// Testbench clock and reset source
//   Free-running clock with a set period
//   Reset held high for a set number of cycles

module clock_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst
);

  // Clock, low at time zero
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release just after an edge, clear of the flops
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

//--- verif/tb_write_weighting.sv
// Testbench for the write-weighting block
//   Element source with random response gaps
//   Fixed-point reference model and expected queue
//   Output monitor, watchdog and closing report

module tb_write_weighting;

  localparam int W         = weighting_pkg::DATA_SIZE;
  localparam int PERIOD    = 100;
  localparam int MAX_GAP   = 5;
  // Sum of N over all runs below and the number of runs
  localparam int TOTAL_ELEMS  = 37;
  localparam int RUN_COUNT    = 10;
  localparam int LIMIT_CYCLES = TOTAL_ELEMS * 2 * (MAX_GAP + 10) + RUN_COUNT * 10;
  localparam logic [W-1:0] ONE = 32'h0001_0000;

  logic clk, rst, start, ready;
  logic a_in_enable, c_in_enable, a_out_enable, c_out_enable, w_out_enable;
  logic [weighting_pkg::SIZE_WIDTH-1:0] size_n_in;
  logic [W-1:0] a_in, c_in, ga_in, gw_in, w_out;

  integer seed;
  int value_errors, protocol_errors;
  int run_n, w_count, req_count, ready_count;
  bit run_active, split_order, prev_w;
  logic [W-1:0] exp_q[$];
  logic [W-1:0] a_stim[$];
  logic [W-1:0] c_stim[$];

  clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(2)) i_clock (.clk(clk), .rst(rst));

  write_weighting_top i_dut (
    .CLK (clk), .RST (rst), .START (start), .READY (ready),
    .A_IN_ENABLE (a_in_enable), .C_IN_ENABLE (c_in_enable),
    .A_OUT_ENABLE (a_out_enable), .C_OUT_ENABLE (c_out_enable),
    .W_OUT_ENABLE (w_out_enable), .SIZE_N_IN (size_n_in),
    .A_IN (a_in), .C_IN (c_in), .GA_IN (ga_in), .GW_IN (gw_in), .W_OUT (w_out)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Clamp to the 32-bit signed range
  function automatic logic [W-1:0] sat_word(input longint v);
    if (v > longint'(weighting_pkg::Q_MAX)) return weighting_pkg::Q_MAX;
    if (v < longint'(weighting_pkg::Q_MIN)) return weighting_pkg::Q_MIN;
    return v[W-1:0];
  endfunction

  // Q16 product with half-up rounding
  function automatic logic [W-1:0] round_mul(input logic signed [W-1:0] x,
                                              input logic signed [W-1:0] y);
    longint p;
    p = longint'(x) * longint'(y);
    p = (p + (longint'(1) <<< (weighting_pkg::FRAC_BITS - 1))) >>> weighting_pkg::FRAC_BITS;
    return sat_word(p);
  endfunction

  // w = gw * (c + ga * (a - c)) with each step saturated
  function automatic logic [W-1:0] ref_weight(input logic signed [W-1:0] a,
    input logic signed [W-1:0] c, input logic signed [W-1:0] ga,
    input logic signed [W-1:0] gw);
    logic signed [W-1:0] diff, gated, mixed;
    diff  = sat_word(longint'(a) - longint'(c));
    gated = round_mul(ga, diff);
    mixed = sat_word(longint'(c) + longint'(gated));
    return round_mul(gw, mixed);
  endfunction

  // Gate value in [0, 1.0]
  function automatic logic [W-1:0] rand_gate();
    return {$random(seed)} % (ONE + 1);
  endfunction

  task automatic check_value(input string name, input logic [W-1:0] got,
                             input logic [W-1:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Run one vector of n elements and wait for READY
  task automatic run_vector(input int n, input logic [W-1:0] ga, input logic [W-1:0] gw,
                            input bit saturate, input bit split, input bit spurious);
    logic signed [W-1:0] a, c;
    int j, ready_before;
    for (j = 0; j < n; j++) begin
      if (saturate) begin
        // Opposite signs, alternating direction
        a = j[0] ? 32'h7000_0000 : 32'h9000_0000;
        c = -a;
      end else begin
        a = $random(seed) % 32'sd262144;
        c = $random(seed) % 32'sd262144;
      end
      a_stim.push_back(a);
      c_stim.push_back(c);
      exp_q.push_back(ref_weight(a, c, ga, gw));
    end
    split_order  = split;
    run_n        = n;
    w_count      = 0;
    req_count    = 0;
    run_active   = 1'b1;
    ready_before = ready_count;
    // Called on a clock edge, so START lands on the very next one
    #1;
    start     = 1'b1;
    size_n_in = n[weighting_pkg::SIZE_WIDTH-1:0];
    ga_in     = ga;
    gw_in     = gw;
    @(posedge clk);
    #1;
    // Inputs change after START and latched values must hold
    start     = 1'b0;
    size_n_in = size_n_in + 16'd3;
    ga_in     = ~ga;
    gw_in     = ~gw;
    if (spurious) begin
      repeat (4) @(posedge clk);
      #1 start = 1'b1;
      @(posedge clk);
      #1 start = 1'b0;
    end
    wait (ready_count != ready_before);
    run_active = 1'b0;
    check_value("element requests", req_count, n);
    check_value("W_OUT_ENABLE pulses", w_count, n);
    if (exp_q.size() != 0) begin
      protocol_errors++;
      $display("Run ended with %0d results still missing", exp_q.size());
      exp_q.delete();
    end
  endtask

  // Answer one request with a and c after separate random gaps
  task automatic answer_request(input logic [W-1:0] a, input logic [W-1:0] c);
    int gap_a, gap_c, last, k;
    gap_a = {$random(seed)} % (MAX_GAP + 1);
    gap_c = {$random(seed)} % (MAX_GAP + 1);
    if (split_order && gap_a == gap_c) gap_c = gap_a + 1;
    last = (gap_a > gap_c) ? gap_a : gap_c;
    #1;
    for (k = 0; k <= last; k++) begin
      a_in_enable = (k == gap_a);
      c_in_enable = (k == gap_c);
      // Decoy data outside the enable cycle
      a_in = (k == gap_a) ? a : ~a;
      c_in = (k == gap_c) ? c : ~c;
      @(posedge clk);
      #1;
    end
    a_in_enable = 1'b0;
    c_in_enable = 1'b0;
  endtask

  initial begin
    a_in_enable = 1'b0;
    c_in_enable = 1'b0;
    a_in = '0;
    c_in = '0;
    forever begin
      @(posedge clk);
      if (!rst && (a_out_enable || c_out_enable)) begin
        if (a_out_enable !== c_out_enable) begin
          protocol_errors++;
          $display("A_OUT_ENABLE and C_OUT_ENABLE not pulsed together at %0t", $time);
        end
        req_count++;
        if (a_stim.size() == 0 || c_stim.size() == 0) begin
          protocol_errors++;
          $display("Element requested at %0t with no element left to send", $time);
        end else begin
          answer_request(a_stim.pop_front(), c_stim.pop_front());
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Monitor and watchdog
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst) begin
      if (w_out_enable) begin
        w_count++;
        if (exp_q.size() == 0) begin
          protocol_errors++;
          $display("W_OUT_ENABLE at %0t with no result expected", $time);
        end else begin
          check_value("W_OUT", w_out, exp_q.pop_front());
        end
      end
      if (ready) begin
        if (!run_active) begin
          protocol_errors++;
          $display("READY at %0t with no run in progress", $time);
        end else if (w_count != run_n) begin
          protocol_errors++;
          $display("READY at %0t after %0d results instead of %0d", $time, w_count, run_n);
        end else if (run_n > 0 && !prev_w) begin
          protocol_errors++;
          $display("READY at %0t not in the cycle after the last result", $time);
        end
        ready_count++;
      end
      prev_w = w_out_enable;
    end
  end

  initial begin
    #(LIMIT_CYCLES * PERIOD);
    $display("Watchdog expired after %0d cycles, the run did not complete", LIMIT_CYCLES);
    $display("tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed      = 32'h3626f1ee;
    start     = 1'b0;
    size_n_in = '0;
    ga_in     = '0;
    gw_in     = '0;
    @(negedge rst);
    // Quiet outputs after reset
    repeat (3) begin
      @(posedge clk);
      check_value("READY", ready, 1'b0);
      check_value("A_OUT_ENABLE", a_out_enable, 1'b0);
      check_value("C_OUT_ENABLE", c_out_enable, 1'b0);
      check_value("W_OUT_ENABLE", w_out_enable, 1'b0);
    end
    // Random vector
    run_vector(8, rand_gate(), rand_gate(), 1'b0, 1'b0, 1'b0);
    // Gate extremes
    run_vector(4, '0, rand_gate(), 1'b0, 1'b0, 1'b0);
    run_vector(4, ONE, rand_gate(), 1'b0, 1'b0, 1'b0);
    run_vector(4, rand_gate(), '0, 1'b0, 1'b0, 1'b0);
    // Saturation with ga 0.5 and gw 3.0
    run_vector(4, 32'h0000_8000, 32'h0003_0000, 1'b1, 1'b0, 1'b0);
    // Split inputs and an ignored START mid run
    run_vector(6, rand_gate(), rand_gate(), 1'b0, 1'b1, 1'b1);
    // Single element, back-to-back runs, empty vector
    run_vector(1, rand_gate(), rand_gate(), 1'b0, 1'b0, 1'b0);
    run_vector(3, rand_gate(), rand_gate(), 1'b0, 1'b0, 1'b0);
    run_vector(3, rand_gate(), rand_gate(), 1'b0, 1'b1, 1'b0);
    run_vector(0, rand_gate(), rand_gate(), 1'b0, 1'b0, 1'b0);
    repeat (3) @(posedge clk);
    $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- compile.f
logic/weighting_pkg.sv
logic/arith_op_if.sv
logic/q_adder.sv
logic/q_multiplier.sv
logic/write_weighting_ctrl.sv
logic/write_weighting_top.sv
verif/clock_gen.sv
verif/tb_write_weighting.sv

//--- Bender.yml
package:
  name: write_weighting

sources:
  # Package and interface first, then the design bottom up
  - files:
      - logic/weighting_pkg.sv
      - logic/arith_op_if.sv
      - logic/q_adder.sv
      - logic/q_multiplier.sv
      - logic/write_weighting_ctrl.sv
      - logic/write_weighting_top.sv

  - target: simulation
    files:
      - verif/clock_gen.sv
      - verif/tb_write_weighting.sv
